// ==== src/bcd_defs.svh ====
`ifndef BCD_DEFS_SVH
`define BCD_DEFS_SVH

// binary input word width
`define BCD_BIN_W 32

// decimal digits needed to hold the largest 32-bit value
`define BCD_DIGITS 10

// four bits per digit
`define BCD_OUT_W 40

// slots in each buffer
// also the number of credits the producer starts with
`define BCD_FIFO_DEPTH 4

// credits granted by the consumer at reset
`define BCD_OUT_CREDITS 2

`endif

// ==== src/bcd_pkg.sv ====
`include "bcd_defs.svh"

package bcd_pkg;

    // unsigned binary word from the producer
    typedef logic [`BCD_BIN_W-1:0] bin_t;

    // one converted value
    // digit 0 sits in the lowest nibble
    typedef struct packed {
        logic [`BCD_OUT_W-1:0] digits;
        logic [3:0]            sig_digits;
    } bcd_result_t;

endpackage

// ==== src/credit_fifo.sv ====
`timescale 1ns/100ps

module credit_fifo #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 4
) (
    input  logic CLK100MHz,
    input  logic arst_n,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     head,
    output logic not_empty,
    output logic not_full,
    output logic pop_credit
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end else begin
            return p + 1'b1;
        end
    endfunction

    assign not_empty = (count != '0);
    assign not_full  = (count != CNT_W'(DEPTH));
    assign do_push   = push && not_full;
    assign do_pop    = pop && not_empty;

    // show-ahead: the reader sees the oldest entry before popping it
    assign head = mem[rd_ptr];

    always_ff @(posedge CLK100MHz or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            pop_credit <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per freed slot, a cycle after the pop
            pop_credit <= do_pop;
        end
    end

    always_ff @(posedge CLK100MHz) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// ==== src/bcd_converter.sv ====
`timescale 1ns/100ps
`include "bcd_defs.svh"

module bcd_converter (
    input  logic                 CLK100MHz,
    input  logic                 arst_n,
    input  logic                 word_valid,
    input  bcd_pkg::bin_t        word,
    input  logic                 res_ready,
    output logic                 word_pop,
    output logic                 res_valid,
    output bcd_pkg::bcd_result_t res
);
    // working register is {digits, binary}
    localparam int WORK_W = `BCD_OUT_W + `BCD_BIN_W;
    localparam int CNT_W  = $clog2(`BCD_BIN_W);

    typedef enum logic [1:0] {
        IDLE,
        CONVERT,
        DONE
    } state_t;

    state_t            state;
    logic [CNT_W-1:0]  shift_cnt;
    logic [WORK_W-1:0] work;
    logic [WORK_W-1:0] corrected;
    logic [3:0]        sig_next;
    logic [3:0]        sig_q;

    assign word_pop = (state == IDLE) && word_valid;

    // add 3 to every digit above 4 before the shift
    // a digit is at most 9 here so no carry reaches the next nibble
    always_comb begin
        corrected = work;
        for (int i = 0; i < `BCD_DIGITS; i++) begin
            if (work[`BCD_BIN_W + 4*i +: 4] > 4'd4) begin
                corrected[`BCD_BIN_W + 4*i +: 4] = work[`BCD_BIN_W + 4*i +: 4] + 4'd3;
            end
        end
    end

    // highest non-zero digit sets the count, zero still shows one digit
    always_comb begin
        sig_next = 4'd1;
        for (int i = 0; i < `BCD_DIGITS; i++) begin
            if (work[`BCD_BIN_W + 4*i +: 4] != 4'd0) begin
                sig_next = 4'(i + 1);
            end
        end
    end

    always_ff @(posedge CLK100MHz or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            shift_cnt <= '0;
            res_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (word_pop) begin
                        shift_cnt <= '0;
                        state     <= CONVERT;
                    end
                end
                CONVERT: begin
                    shift_cnt <= shift_cnt + 1'b1;
                    if (shift_cnt == CNT_W'(`BCD_BIN_W - 1)) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    // first cycle here forms sig_digits, then hold for the buffer
                    if (!res_valid) begin
                        res_valid <= 1'b1;
                    end else if (res_ready) begin
                        res_valid <= 1'b0;
                        state     <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge CLK100MHz) begin
        if (word_pop) begin
            work <= {{`BCD_OUT_W{1'b0}}, word};
        end else if (state == CONVERT) begin
            work <= corrected << 1;
        end
        if ((state == DONE) && !res_valid) begin
            sig_q <= sig_next;
        end
    end

    assign res.digits     = work[WORK_W-1 -: `BCD_OUT_W];
    assign res.sig_digits = sig_q;

endmodule

// ==== src/credit_tx.sv ====
`timescale 1ns/100ps
`include "bcd_defs.svh"

module credit_tx (
    input  logic                  CLK100MHz,
    input  logic                  arst_n,
    input  logic                  res_valid,
    input  bcd_pkg::bcd_result_t  res,
    input  logic                  out_credit,
    output logic                  res_ready,
    output logic                  out_valid,
    output logic [`BCD_OUT_W-1:0] out_digits,
    output logic [3:0]            out_sig_digits
);
    localparam int CREDIT_W = $clog2(`BCD_OUT_CREDITS + 1);

    bcd_pkg::bcd_result_t head;
    logic                 buf_not_empty;
    logic                 buf_not_full;
    logic                 send;
    logic [CREDIT_W-1:0]  credit_cnt;

    assign res_ready = buf_not_full;
    assign send      = buf_not_empty && (credit_cnt != '0);

    // consumer credits pace this buffer, so its own pop credit stays open
    credit_fifo #(
        .T     (bcd_pkg::bcd_result_t),
        .DEPTH (`BCD_FIFO_DEPTH)
    ) u_res_fifo (
        .CLK100MHz  (CLK100MHz),
        .arst_n     (arst_n),
        .push       (res_valid && buf_not_full),
        .push_data  (res),
        .pop        (send),
        .head       (head),
        .not_empty  (buf_not_empty),
        .not_full   (buf_not_full),
        .pop_credit ()
    );

    always_ff @(posedge CLK100MHz or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= CREDIT_W'(`BCD_OUT_CREDITS);
            out_valid  <= 1'b0;
        end else begin
            // send and return in one cycle cancel out
            case ({send, out_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
            out_valid <= send;
        end
    end

    always_ff @(posedge CLK100MHz) begin
        if (send) begin
            out_digits     <= head.digits;
            out_sig_digits <= head.sig_digits;
        end
    end

endmodule

// ==== src/bcd_path.sv ====
`timescale 1ns/100ps
`include "bcd_defs.svh"

module bcd_path (
    input  logic                  CLK100MHz,
    input  logic                  arst_n,
    input  logic                  in_valid,
    input  bcd_pkg::bin_t         in_data,
    input  logic                  out_credit,
    output logic                  in_credit,
    output logic                  out_valid,
    output logic [`BCD_OUT_W-1:0] out_digits,
    output logic [3:0]            out_sig_digits
);
    bcd_pkg::bin_t        word_head;
    logic                 word_valid;
    logic                 word_pop;
    logic                 res_valid;
    logic                 res_ready;
    bcd_pkg::bcd_result_t res;

    // producer only sends with a credit, so the full flag is not needed here
    credit_fifo #(
        .T     (bcd_pkg::bin_t),
        .DEPTH (`BCD_FIFO_DEPTH)
    ) u_in_fifo (
        .CLK100MHz  (CLK100MHz),
        .arst_n     (arst_n),
        .push       (in_valid),
        .push_data  (in_data),
        .pop        (word_pop),
        .head       (word_head),
        .not_empty  (word_valid),
        .not_full   (),
        .pop_credit (in_credit)
    );

    bcd_converter u_conv (
        .CLK100MHz  (CLK100MHz),
        .arst_n     (arst_n),
        .word_valid (word_valid),
        .word       (word_head),
        .res_ready  (res_ready),
        .word_pop   (word_pop),
        .res_valid  (res_valid),
        .res        (res)
    );

    credit_tx u_tx (
        .CLK100MHz      (CLK100MHz),
        .arst_n         (arst_n),
        .res_valid      (res_valid),
        .res            (res),
        .out_credit     (out_credit),
        .res_ready      (res_ready),
        .out_valid      (out_valid),
        .out_digits     (out_digits),
        .out_sig_digits (out_sig_digits)
    );

endmodule

// ==== verification/bcd_path_asserts.sv ====
`timescale 1ns/100ps
`include "bcd_defs.svh"

module bcd_path_asserts (
    input logic                                    CLK100MHz,
    input logic                                    arst_n,
    input logic [$clog2(`BCD_OUT_CREDITS + 1)-1:0] credit_cnt,
    input logic                                    in_push,
    input logic                                    in_not_full,
    input logic                                    out_valid,
    input logic [`BCD_OUT_W-1:0]                   out_digits,
    input logic [3:0]                              out_sig_digits
);
    function automatic logic digits_in_range(input logic [`BCD_OUT_W-1:0] d);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < `BCD_DIGITS; i++) begin
            if (d[4*i +: 4] > 4'd9) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // out_valid follows a send, which needs a credit the cycle before
    a_send_needs_credit: assert property (@(posedge CLK100MHz) disable iff (!arst_n)
        out_valid |-> ($past(credit_cnt) != '0))
        else $error("out_valid without an output credit");

    // the producer may only push into a free slot
    a_in_push_full: assert property (@(posedge CLK100MHz) disable iff (!arst_n)
        in_push |-> in_not_full)
        else $error("input buffer pushed while full");

    a_digit_range: assert property (@(posedge CLK100MHz) disable iff (!arst_n)
        out_valid |-> digits_in_range(out_digits))
        else $error("output digit above 9");

    a_sig_range: assert property (@(posedge CLK100MHz) disable iff (!arst_n)
        out_valid |-> ((out_sig_digits >= 4'd1) && (out_sig_digits <= 4'd10)))
        else $error("out_sig_digits outside 1 to 10");

endmodule

bind bcd_path bcd_path_asserts u_asserts (
    .CLK100MHz      (CLK100MHz),
    .arst_n         (arst_n),
    .credit_cnt     (u_tx.credit_cnt),
    .in_push        (in_valid),
    .in_not_full    (u_in_fifo.not_full),
    .out_valid      (out_valid),
    .out_digits     (out_digits),
    .out_sig_digits (out_sig_digits)
);

// ==== verification/bcd_path_tb.sv ====
`timescale 1ns/100ps
`include "bcd_defs.svh"

module bcd_path_tb;
    localparam int N_EDGE     = 13;
    localparam int N_WORDS    = N_EDGE + 200;
    localparam int HOLD_FILL  = 600;
    localparam int HOLD_QUIET = 200;
    // about 100 cycles per word, plus reset, the credit stall and a margin
    localparam int TIMEOUT_CYCLES = N_WORDS * 100 + 16 + HOLD_FILL + HOLD_QUIET + 1000;
    localparam bcd_pkg::bin_t EDGE_WORDS [N_EDGE] = '{
        32'd0, 32'd9, 32'd10, 32'd100, 32'd1000, 32'd10000, 32'd100000, 32'd1000000,
        32'd10000000, 32'd100000000, 32'd1000000000, 32'd99999999, 32'd4294967295
    };

    logic                  CLK100MHz;
    logic                  arst_n;
    logic                  in_valid;
    bcd_pkg::bin_t         in_data;
    logic                  out_credit;
    logic                  in_credit;
    logic                  out_valid;
    logic [`BCD_OUT_W-1:0] out_digits;
    logic [3:0]            out_sig_digits;

    bcd_pkg::bin_t        words [N_WORDS];
    bcd_pkg::bcd_result_t expected_q [$];
    integer               seed;
    int                   prod_credits;
    int                   sent_cnt;
    int                   in_credit_cnt;
    int                   granted_cnt;
    int                   out_cnt;
    int                   owed;
    logic                 hold_credits;

    bcd_path dut (
        .CLK100MHz      (CLK100MHz),
        .arst_n         (arst_n),
        .in_valid       (in_valid),
        .in_data        (in_data),
        .out_credit     (out_credit),
        .in_credit      (in_credit),
        .out_valid      (out_valid),
        .out_digits     (out_digits),
        .out_sig_digits (out_sig_digits)
    );

    // digits by repeated division, count from the top non-zero digit
    function automatic bcd_pkg::bcd_result_t reference_result(input bcd_pkg::bin_t value);
        bcd_pkg::bcd_result_t r;
        logic [31:0]          rest;
        rest         = value;
        r.digits     = '0;
        r.sig_digits = 4'd1;
        for (int i = 0; i < `BCD_DIGITS; i++) begin
            r.digits[4*i +: 4] = 4'(rest % 10);
            if ((rest % 10) != 0) begin
                r.sig_digits = 4'(i + 1);
            end
            rest = rest / 10;
        end
        return r;
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_output();
        bcd_pkg::bcd_result_t exp;
        if (expected_q.size() == 0) begin
            stop_with_failure("out_valid came with no result outstanding");
        end else begin
            exp = expected_q.pop_front();
            assert (out_digits == exp.digits) else
                stop_with_failure($sformatf("[ERROR] time %0t: out_digits expected %h, got %h",
                    $time, exp.digits, out_digits));
            assert (out_sig_digits == exp.sig_digits) else
                stop_with_failure($sformatf("[ERROR] time %0t: out_sig_digits expected %0d, got %0d",
                    $time, exp.sig_digits, out_sig_digits));
        end
    endtask

    // producer sends only while it holds a credit
    task automatic send_words();
        int i;
        i = 0;
        while (i < N_WORDS) begin
            @(posedge CLK100MHz);
            #1;
            if (prod_credits > 0) begin
                in_valid = 1'b1;
                in_data  = words[i];
                expected_q.push_back(reference_result(words[i]));
                prod_credits--;
                sent_cnt++;
                i++;
            end else begin
                in_valid = 1'b0;
            end
        end
        @(posedge CLK100MHz);
        #1;
        in_valid = 1'b0;
    endtask

    // withhold output credits until the whole path is full
    task automatic stall_consumer();
        int mark;
        wait (sent_cnt >= 30);
        @(posedge CLK100MHz);
        hold_credits = 1'b1;
        repeat (HOLD_FILL) @(posedge CLK100MHz);
        // counters only move on the rising edge
        @(negedge CLK100MHz);
        mark = in_credit_cnt;
        assert (prod_credits == 0) else
            stop_with_failure("producer still holds input credits during the output stall");
        repeat (HOLD_QUIET) @(posedge CLK100MHz);
        @(negedge CLK100MHz);
        assert (in_credit_cnt == mark) else
            stop_with_failure($sformatf("[ERROR] time %0t: in_credit pulses expected %0d, got %0d",
                $time, mark, in_credit_cnt));
        hold_credits = 1'b0;
    endtask

    always @(posedge CLK100MHz) begin
        if (arst_n) begin
            if (in_credit) begin
                in_credit_cnt++;
                prod_credits++;
            end
            if (out_credit) begin
                granted_cnt++;
            end
            if (out_valid) begin
                out_cnt++;
                owed++;
                assert (out_cnt <= granted_cnt + `BCD_OUT_CREDITS) else
                    stop_with_failure($sformatf("[ERROR] time %0t: out_valid count max %0d, got %0d",
                        $time, granted_cnt + `BCD_OUT_CREDITS, out_cnt));
                check_output();
            end
            assert (prod_credits <= `BCD_FIFO_DEPTH) else
                stop_with_failure("more input credits returned than the input buffer has slots");
        end
    end

    // consumer frees slots after random delays
    always @(posedge CLK100MHz) begin
        #1;
        if (arst_n && !hold_credits && (owed > 0) && (($random(seed) & 3) == 0)) begin
            out_credit = 1'b1;
            owed--;
        end else begin
            out_credit = 1'b0;
        end
    end

    initial begin
        CLK100MHz = 1'b0;
        forever #5 CLK100MHz = ~CLK100MHz;
    end

    initial begin
        #(TIMEOUT_CYCLES * 10);
        stop_with_failure($sformatf("timeout: only %0d of %0d results after %0d cycles",
            out_cnt, N_WORDS, TIMEOUT_CYCLES));
    end

    initial begin
        arst_n        = 1'b0;
        in_valid      = 1'b0;
        in_data       = '0;
        out_credit    = 1'b0;
        hold_credits  = 1'b0;
        seed          = 32'hdc185cc8;
        prod_credits  = `BCD_FIFO_DEPTH;
        sent_cnt      = 0;
        in_credit_cnt = 0;
        granted_cnt   = 0;
        out_cnt       = 0;
        owed          = 0;
        for (int i = 0; i < N_WORDS; i++) begin
            words[i] = (i < N_EDGE) ? EDGE_WORDS[i] : $random(seed);
        end
        repeat (16) @(posedge CLK100MHz);
        #1;
        arst_n = 1'b1;
        fork
            send_words();
            stall_consumer();
        join
        wait (out_cnt == N_WORDS);
        repeat (10) @(posedge CLK100MHz);
        if ((expected_q.size() == 0) && (in_credit_cnt == sent_cnt)) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_with_failure($sformatf("drained with %0d results left, %0d of %0d credits back",
                expected_q.size(), in_credit_cnt, sent_cnt));
        end
    end

endmodule

// ==== bcd_path.f ====
+incdir+src
src/bcd_pkg.sv
src/credit_fifo.sv
src/bcd_converter.sv
src/credit_tx.sv
src/bcd_path.sv
verification/bcd_path_asserts.sv
verification/bcd_path_tb.sv

// ==== Makefile ====
TOP        ?= bcd_path_tb
FILELIST   ?= bcd_path.f
VERILATOR  ?= verilator
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
